//--- Bender.yml
package:
  name: ecc_store

sources:
  - src/ecc_pkg.sv
  - src/ecc_bus_pkg.sv
  - src/ecc_44_cal.sv
  - src/ecc_apb_regs.sv
  - src/ecc_write_stage.sv
  - src/ecc_mem_stage.sv
  - src/ecc_correct_stage.sv
  - src/ecc_top.sv
  - target: test
    files:
      - bench/ecc_tb.sv

//--- bench/ecc_tb.sv
`timescale 1ns/10ps

module ecc_tb
    import ecc_pkg::*;
    import ecc_bus_pkg::*;
();

    localparam int DEPTH           = 16;
    localparam int NUM_ROUNDS      = 300;
    localparam int NUM_CMD_ROUNDS  = DEPTH + CODE_WIDTH + NUM_ROUNDS + 8;
    localparam int XFERS_PER_ROUND = 12;
    localparam int LONGEST_XFER    = 7;    // idle, setup, access, 3 waits, spare.
    localparam int CYCLE_LIMIT     = 2 * NUM_CMD_ROUNDS * XFERS_PER_ROUND * LONGEST_XFER + 16;

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [31:0] lfsr;
    data_t       model_data  [DEPTH];
    data_t       model_dmask [DEPTH];   // flipped data bits of the last write.
    int          model_nflip [DEPTH];
    logic [15:0] exp_scnt;
    logic [15:0] exp_dcnt;
    int          value_errs;
    int          xfer_errs;
    int          cycle_cnt;

    ecc_top #(.DEPTH(DEPTH)) ecc_top_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // codeword positions that end up inverted.
    function automatic logic [63:0] flip_positions(logic en_a, logic [5:0] idx_a,
                                                   logic en_b, logic [5:0] idx_b);
        logic [63:0] m;
        logic        use_a;
        logic        use_b;
        use_a = en_a && idx_a < CODE_WIDTH;
        use_b = en_b && idx_b < CODE_WIDTH;
        m = '0;
        if (use_a && use_b && idx_a == idx_b)
            return m;                     // the two flips undo each other.
        if (use_a)
            m[idx_a] = 1'b1;
        if (use_b)
            m[idx_b] = 1'b1;
        return m;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %0d ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_xfer(input string what, input int waits, input int exp_waits,
                              input logic slverr, input logic exp_err);
        assert (waits == exp_waits && slverr === exp_err) else begin
            $display("ERR %0d ns: %s took %0d wait states with pslverr %0b, expected %0d and %0b",
                     $time, what, waits, slverr, exp_waits, exp_err);
            xfer_errs++;
        end
    endtask

    task automatic apb_xfer(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr, output int waits);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;   // first access cycle.
        waits = 0;
        @(posedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(posedge clk);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata,
                             input int exp_waits);
        logic [31:0] rdata;
        logic        slverr;
        int          waits;
        apb_xfer(addr, 1'b1, wdata, rdata, slverr, waits);
        check_xfer($sformatf("write 0x%02h", addr), waits, exp_waits, slverr, 1'b0);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic slverr;
        int   waits;
        apb_xfer(addr, 1'b0, 32'h0, rdata, slverr, waits);
        check_xfer($sformatf("read 0x%02h", addr), waits, 0, slverr, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // commands and reference model
    // ------------------------------------------------------------------------
    task automatic cmd_write(input logic [7:0] addr, input data_t data, input logic en_a,
                             input logic [5:0] idx_a, input logic en_b, input logic [5:0] idx_b);
        logic [63:0] m;
        reg_write(FLIP, {17'b0, en_b, idx_b, 1'b0, en_a, idx_a}, 0);
        reg_write(DATA_LO, data[31:0], 0);
        reg_write(DATA_HI, 32'(data[DATA_WIDTH-1:32]), 0);
        reg_write(CMD, {23'b0, 1'b0, addr}, 3);
        m = flip_positions(en_a, idx_a, en_b, idx_b);
        model_data[addr[3:0]]  = data;
        model_dmask[addr[3:0]] = m[DATA_WIDTH-1:0];
        model_nflip[addr[3:0]] = $countones(m);
    endtask

    task automatic cmd_read(input logic [7:0] addr, input logic bypass);
        data_t       exp;
        logic        exp_s;
        logic        exp_d;
        logic [31:0] rd;
        exp   = model_data[addr[3:0]];
        exp_s = 1'b0;
        exp_d = 1'b0;
        if (bypass) begin
            exp ^= model_dmask[addr[3:0]];   // raw data, flags held low.
        end else if (model_nflip[addr[3:0]] == 1) begin
            exp_s = 1'b1;
            if (exp_scnt != 16'hFFFF)
                exp_scnt++;
        end else if (model_nflip[addr[3:0]] == 2) begin
            exp  ^= model_dmask[addr[3:0]];
            exp_d = 1'b1;
            if (exp_dcnt != 16'hFFFF)
                exp_dcnt++;
        end
        reg_write(CTRL, 32'(bypass), 0);
        reg_write(CMD, {23'b0, 1'b1, addr}, 3);
        reg_read(CMD, rd);
        check_value("CMD readback", rd, {23'b0, 1'b1, addr});
        reg_read(DATA_LO, rd);
        check_value($sformatf("DATA_LO of word %0d", addr), rd, exp[31:0]);
        reg_read(DATA_HI, rd);
        check_value($sformatf("DATA_HI of word %0d", addr), rd, 32'(exp[DATA_WIDTH-1:32]));
        reg_read(STATUS, rd);
        check_value($sformatf("STATUS of word %0d", addr), rd, {30'b0, exp_d, exp_s});
        reg_read(COUNT, rd);
        check_value("COUNT", rd, {exp_dcnt, exp_scnt});
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic        slverr;
        int          waits;
        logic [7:0]  addr;
        logic [1:0]  mode;
        data_t       wdata;
        logic [5:0]  idx_a;
        logic [5:0]  idx_b;
        apb_req    = '0;
        rst        = 1'b1;
        lfsr       = 32'h68aa_1eda;
        exp_scnt   = '0;
        exp_dcnt   = '0;
        value_errs = 0;
        xfer_errs  = 0;
        cycle_cnt  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reg_read(COUNT, rd);
        check_value("COUNT after reset", rd, 32'h0);
        reg_read(STATUS, rd);
        check_value("STATUS after reset", rd, 32'h0);
        reg_read(FLIP, rd);
        check_value("FLIP after reset", rd, 32'h0);
        reg_read(CTRL, rd);
        check_value("CTRL after reset", rd, 32'h0);

        // out of range word addresses and unmapped offsets.
        apb_xfer(CMD, 1'b1, {23'b0, 1'b0, 8'(16 + rand_bits(7))}, rd, slverr, waits);
        check_xfer("write CMD beyond DEPTH", waits, 0, slverr, 1'b1);
        apb_xfer(CMD, 1'b1, {23'b0, 1'b1, 8'hFF}, rd, slverr, waits);
        check_xfer("read CMD beyond DEPTH", waits, 0, slverr, 1'b1);
        apb_xfer(8'h1C, 1'b1, 32'h1, rd, slverr, waits);
        check_xfer("write 0x1c", waits, 0, slverr, 1'b1);
        apb_xfer(8'h40, 1'b0, 32'h0, rd, slverr, waits);
        check_xfer("read 0x40", waits, 0, slverr, 1'b1);
        reg_read(CMD, rd);
        check_value("CMD after rejected commands", rd, 32'h0);

        for (int a = 0; a < DEPTH; a++) begin
            cmd_write(8'(a), data_t'(rand_bits(DATA_WIDTH)), 1'b0, 6'd0, 1'b0, 6'd0);
            cmd_read(8'(a), 1'b0);
        end

        // one flip at every codeword position.
        for (int pos = 0; pos < CODE_WIDTH; pos++) begin
            addr = 8'(pos % DEPTH);
            cmd_write(addr, data_t'(rand_bits(DATA_WIDTH)), 1'b1, 6'(pos), 1'b0, 6'd0);
            cmd_read(addr, 1'b0);
        end

        reg_write(COUNT, 32'hFFFF_FFFF, 0);
        exp_scnt = '0;
        exp_dcnt = '0;
        reg_read(COUNT, rd);
        check_value("COUNT after clear", rd, 32'h0);

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            addr  = 8'(rand_bits(4));
            mode  = 2'(rand_bits(2));
            wdata = data_t'(rand_bits(DATA_WIDTH));
            idx_a = 6'(rand_bits(6));
            idx_b = 6'(rand_bits(6));
            cmd_write(addr, wdata, mode != 2'd0, idx_a, mode >= 2'd2, idx_b);
            addr = 8'(rand_bits(4));
            cmd_read(addr, rand_bits(2) == 64'd0);
        end

        reg_write(COUNT, 32'h0, 0);
        exp_scnt = '0;
        exp_dcnt = '0;
        reg_read(COUNT, rd);
        check_value("COUNT after final clear", rd, 32'h0);

        $display("errors: %0d value, %0d transfer", value_errs, xfer_errs);
        if (value_errs == 0 && xfer_errs == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- list.f
src/ecc_pkg.sv
src/ecc_bus_pkg.sv
src/ecc_44_cal.sv
src/ecc_apb_regs.sv
src/ecc_write_stage.sv
src/ecc_mem_stage.sv
src/ecc_correct_stage.sv
src/ecc_top.sv
bench/ecc_tb.sv

//--- src/ecc_44_cal.sv
`timescale 1ns/10ps

module ecc_44_cal
    import ecc_pkg::*;
(
    input  data_t   data_in,
    input  parity_t parity_in,
    input  logic    bypass,
    output data_t   data_out,
    output parity_t parity_out,
    output data_t   mask,
    output logic    sbit_err,
    output logic    dbit_err
);

    parity_t syndrome;
    logic    parity_hit;
    logic    multi_hit;

    assign parity_out = ecc_check_bits(data_in);
    assign syndrome   = parity_out ^ parity_in;

    // ------------------------------------------------------------------------
    // syndrome decode
    // ------------------------------------------------------------------------
    always_comb begin
        mask       = '0;
        parity_hit = 1'b0;
        multi_hit  = 1'b0;
        case (syndrome)
            7'h00: ;                       // clean word.
            7'h43: mask[0]  = 1'b1;
            7'h45: mask[1]  = 1'b1;
            7'h46: mask[2]  = 1'b1;
            7'h07: mask[3]  = 1'b1;
            7'h49: mask[4]  = 1'b1;
            7'h4A: mask[5]  = 1'b1;
            7'h0B: mask[6]  = 1'b1;
            7'h4C: mask[7]  = 1'b1;
            7'h0D: mask[8]  = 1'b1;
            7'h0E: mask[9]  = 1'b1;
            7'h4F: mask[10] = 1'b1;
            7'h51: mask[11] = 1'b1;
            7'h52: mask[12] = 1'b1;
            7'h13: mask[13] = 1'b1;
            7'h54: mask[14] = 1'b1;
            7'h15: mask[15] = 1'b1;
            7'h16: mask[16] = 1'b1;
            7'h57: mask[17] = 1'b1;
            7'h58: mask[18] = 1'b1;
            7'h19: mask[19] = 1'b1;
            7'h1A: mask[20] = 1'b1;
            7'h5B: mask[21] = 1'b1;
            7'h1C: mask[22] = 1'b1;
            7'h5D: mask[23] = 1'b1;
            7'h5E: mask[24] = 1'b1;
            7'h1F: mask[25] = 1'b1;
            7'h61: mask[26] = 1'b1;
            7'h62: mask[27] = 1'b1;
            7'h23: mask[28] = 1'b1;
            7'h64: mask[29] = 1'b1;
            7'h25: mask[30] = 1'b1;
            7'h26: mask[31] = 1'b1;
            7'h67: mask[32] = 1'b1;
            7'h68: mask[33] = 1'b1;
            7'h29: mask[34] = 1'b1;
            7'h2A: mask[35] = 1'b1;
            7'h6B: mask[36] = 1'b1;
            7'h2C: mask[37] = 1'b1;
            7'h6D: mask[38] = 1'b1;
            7'h6E: mask[39] = 1'b1;
            7'h2F: mask[40] = 1'b1;
            7'h70: mask[41] = 1'b1;
            7'h31: mask[42] = 1'b1;
            7'h32: mask[43] = 1'b1;
            // a flipped check bit leaves the data alone.
            7'h01, 7'h02, 7'h04, 7'h08, 7'h10, 7'h20, 7'h40:
                parity_hit = 1'b1;
            default:
                multi_hit = 1'b1;         // even weight, uncorrectable.
        endcase
    end

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && ((|mask) || parity_hit);
    assign dbit_err = !bypass && multi_hit;

    // each table entry must match its column of the check matrix.
    mask_col_a: assert final ((mask == '0) || (ecc_check_bits(mask) == syndrome))
        else $error("ecc_44_cal: correction mask does not match the syndrome");

endmodule

//--- src/ecc_apb_regs.sv
`timescale 1ns/10ps

module ecc_apb_regs
    import ecc_pkg::*;
    import ecc_bus_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output ecc_req_t req,
    input  ecc_rsp_t rsp,
    output flip_t    flip
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_e;

    state_e   state;
    data_t    data_q;
    cmd_reg_t cmd_q;
    logic     bypass_q;
    status_t  status_q;
    count_t   count_q;

    logic     access;
    logic     wr;
    logic     addr_hit;
    logic     is_cmd;
    logic     cmd_bad;
    logic     issue;
    logic     rd_done;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr      = access && apb_req.pwrite;
    assign is_cmd  = apb_req.paddr == CMD;
    assign cmd_bad = apb_req.pwdata[7:0] >= DEPTH;
    assign issue   = wr && is_cmd && !cmd_bad && state == IDLE;
    assign rd_done = rsp.valid && rsp.op == OP_READ;

    // ------------------------------------------------------------------------
    // decode and read mux
    // ------------------------------------------------------------------------
    always_comb begin
        addr_hit       = 1'b1;
        apb_rsp.prdata = '0;
        case (reg_addr_e'(apb_req.paddr))
            DATA_LO: apb_rsp.prdata = data_q[31:0];
            DATA_HI: apb_rsp.prdata = 32'(data_q[DATA_WIDTH-1:32]);
            CMD:     apb_rsp.prdata = 32'(cmd_q);
            FLIP:    apb_rsp.prdata = 32'(flip);
            CTRL:    apb_rsp.prdata = 32'(bypass_q);
            STATUS:  apb_rsp.prdata = 32'(status_q);
            COUNT:   apb_rsp.prdata = count_q;
            default: addr_hit = 1'b0;
        endcase
    end

    // a command holds the bus until its completion returns.
    assign apb_rsp.pready  = (state == WAIT) ? rsp.valid : !issue;
    assign apb_rsp.pslverr = access && (!addr_hit || (wr && is_cmd && cmd_bad));

    always_comb begin
        req        = '0;
        req.valid  = issue;
        req.op     = ecc_op_e'(apb_req.pwdata[8]);
        req.addr   = apb_req.pwdata[7:0];
        req.data   = data_q;
        req.bypass = bypass_q;
    end

    // ------------------------------------------------------------------------
    // control state, status and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cmd_q    <= '0;
            flip     <= '0;
            bypass_q <= 1'b0;
            status_q <= '0;
            count_q  <= '0;
        end else begin
            case (state)
                IDLE: if (issue) state <= WAIT;
                WAIT: if (rsp.valid) state <= IDLE;
            endcase
            if (issue)
                cmd_q <= cmd_reg_t'(apb_req.pwdata[8:0]);
            if (wr) begin
                case (reg_addr_e'(apb_req.paddr))
                    FLIP: begin
                        flip      <= flip_t'(apb_req.pwdata[$bits(flip_t)-1:0]);
                        flip.rsvd <= 1'b0;
                    end
                    CTRL:    bypass_q <= apb_req.pwdata[0];
                    COUNT:   count_q  <= '0;
                    default: ;
                endcase
            end
            if (rd_done) begin
                status_q.sbit <= rsp.sbit;
                status_q.dbit <= rsp.dbit;
                if (rsp.sbit && count_q.scnt != 16'hFFFF)
                    count_q.scnt <= count_q.scnt + 16'd1;
                if (rsp.dbit && count_q.dcnt != 16'hFFFF)
                    count_q.dcnt <= count_q.dcnt + 16'd1;   // saturates.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && apb_req.paddr == DATA_LO)
            data_q[31:0] <= apb_req.pwdata;
        if (wr && apb_req.paddr == DATA_HI)
            data_q[DATA_WIDTH-1:32] <= apb_req.pwdata[DATA_WIDTH-33:0];
        if (rd_done)
            data_q <= rsp.data;        // read result replaces staged data.
    end

    rsp_in_wait_a: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> state == WAIT);
    // three pipeline stages between issue and completion.
    rsp_latency_a: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> ##3 rsp.valid);

endmodule

//--- src/ecc_bus_pkg.sv
package ecc_bus_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------
    typedef enum logic [7:0] {
        DATA_LO = 8'h00,
        DATA_HI = 8'h04,
        CMD     = 8'h08,
        FLIP    = 8'h0C,
        CTRL    = 8'h10,
        STATUS  = 8'h14,
        COUNT   = 8'h18
    } reg_addr_e;

    // field layouts, lsb aligned with pwdata bit 0.
    typedef struct packed {
        logic              en_b;
        ecc_pkg::bit_idx_t idx_b;
        logic              rsvd;     // bit 7, reads as zero.
        logic              en_a;
        ecc_pkg::bit_idx_t idx_a;
    } flip_t;

    typedef struct packed {
        ecc_pkg::ecc_op_e op;
        ecc_pkg::addr_t   addr;
    } cmd_reg_t;

    typedef struct packed {
        logic dbit;
        logic sbit;
    } status_t;

    typedef struct packed {
        logic [15:0] dcnt;
        logic [15:0] scnt;
    } count_t;

endpackage

//--- src/ecc_correct_stage.sv
`timescale 1ns/10ps

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ecc_req_t req_in,
    output ecc_rsp_t rsp
);

    data_t corr_data;
    logic  sbit_err;
    logic  dbit_err;

    ecc_44_cal ecc_44_cal_i (
        .data_in    (req_in.code.data),
        .parity_in  (req_in.code.parity),
        .bypass     (req_in.bypass),
        .data_out   (corr_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always_ff @(posedge clk) begin
        rsp.op <= req_in.op;
        if (req_in.op == OP_READ) begin
            rsp.data <= corr_data;
            rsp.sbit <= sbit_err;
            rsp.dbit <= dbit_err;
        end else begin
            rsp.data <= req_in.data;   // write completion, no decode.
            rsp.sbit <= 1'b0;
            rsp.dbit <= 1'b0;
        end
        rsp.valid <= rst ? 1'b0 : req_in.valid;
    end

endmodule

//--- src/ecc_mem_stage.sv
`timescale 1ns/10ps

module ecc_mem_stage
    import ecc_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  ecc_req_t req_in,
    output ecc_req_t req_out
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    code_t          mem [DEPTH];
    logic [AW-1:0]  word;

    assign word = req_in.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (req_in.valid && req_in.op == OP_WRITE)
            mem[word] <= req_in.code;
    end

    // reads pick up the stored codeword at the same edge.
    always_ff @(posedge clk) begin
        req_out <= req_in;
        if (req_in.op == OP_READ)
            req_out.code <= mem[word];
        if (rst)
            req_out.valid <= 1'b0;
    end

    addr_range_a: assert property (@(posedge clk) disable iff (rst)
        req_in.valid |-> req_in.addr < DEPTH);

endmodule

//--- src/ecc_pkg.sv
package ecc_pkg;

    // ------------------------------------------------------------------------
    // word geometry
    // ------------------------------------------------------------------------
    localparam int DATA_WIDTH   = 44;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [5:0]              bit_idx_t;    // codeword bit index.
    typedef logic [7:0]              addr_t;       // word address.

    // parity on top, so codeword bits 0..43 are data.
    typedef struct packed {
        parity_t parity;
        data_t   data;
    } code_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } ecc_op_e;

    typedef struct packed {
        logic    valid;
        ecc_op_e op;
        addr_t   addr;
        data_t   data;
        code_t   code;
        logic    bypass;
    } ecc_req_t;

    typedef struct packed {
        logic    valid;
        ecc_op_e op;
        data_t   data;     // corrected data.
        logic    sbit;
        logic    dbit;
    } ecc_rsp_t;

    // ------------------------------------------------------------------------
    // check matrix columns, one per data bit, all of odd weight.
    // ------------------------------------------------------------------------
    localparam parity_t H_COL [DATA_WIDTH] = '{
        7'h43, 7'h45, 7'h46, 7'h07, 7'h49, 7'h4A, 7'h0B, 7'h4C, 7'h0D, 7'h0E, 7'h4F,
        7'h51, 7'h52, 7'h13, 7'h54, 7'h15, 7'h16, 7'h57, 7'h58, 7'h19, 7'h1A, 7'h5B,
        7'h1C, 7'h5D, 7'h5E, 7'h1F, 7'h61, 7'h62, 7'h23, 7'h64, 7'h25, 7'h26, 7'h67,
        7'h68, 7'h29, 7'h2A, 7'h6B, 7'h2C, 7'h6D, 7'h6E, 7'h2F, 7'h70, 7'h31, 7'h32
    };

    function automatic parity_t ecc_check_bits(data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (d[i])
                p ^= H_COL[i];
        end
        return p;
    endfunction

endpackage

//--- src/ecc_top.sv
`timescale 1ns/10ps

module ecc_top
    import ecc_pkg::*;
    import ecc_bus_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    ecc_req_t req_regs;
    ecc_req_t req_write;
    ecc_req_t req_mem;
    ecc_rsp_t rsp_corr;
    flip_t    flip;

    ecc_apb_regs #(.DEPTH(DEPTH)) regs_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .req     (req_regs),
        .rsp     (rsp_corr),
        .flip    (flip)
    );

    // ------------------------------------------------------------------------
    // encode, store, correct. one cycle each.
    // ------------------------------------------------------------------------
    ecc_write_stage write_i (
        .clk     (clk),
        .rst     (rst),
        .req_in  (req_regs),
        .flip    (flip),
        .req_out (req_write)
    );

    ecc_mem_stage #(.DEPTH(DEPTH)) mem_i (
        .clk     (clk),
        .rst     (rst),
        .req_in  (req_write),
        .req_out (req_mem)
    );

    ecc_correct_stage correct_i (
        .clk    (clk),
        .rst    (rst),
        .req_in (req_mem),
        .rsp    (rsp_corr)
    );

endmodule

//--- src/ecc_write_stage.sv
`timescale 1ns/10ps

module ecc_write_stage
    import ecc_pkg::*;
    import ecc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ecc_req_t req_in,
    input  flip_t    flip,
    output ecc_req_t req_out
);

    code_t                 clean_code;
    logic [CODE_WIDTH-1:0] flip_mask;

    assign clean_code.parity = ecc_check_bits(req_in.data);
    assign clean_code.data   = req_in.data;

    // equal indices cancel, out of range ones drop.
    always_comb begin
        flip_mask = '0;
        if (flip.en_a && flip.idx_a < CODE_WIDTH)
            flip_mask[flip.idx_a] = ~flip_mask[flip.idx_a];
        if (flip.en_b && flip.idx_b < CODE_WIDTH)
            flip_mask[flip.idx_b] = ~flip_mask[flip.idx_b];
    end

    always_ff @(posedge clk) begin
        req_out <= req_in;
        if (req_in.op == OP_WRITE)
            req_out.code <= clean_code ^ flip_mask;
        if (rst)
            req_out.valid <= 1'b0;
    end

endmodule
